// File: source/cpu_pkg.sv
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	// opcode field, inst[30:25]
	typedef enum logic [5:0] {
		op_lw   = 6'b000010,
		op_sw   = 6'b001010,
		op_alu  = 6'b100000,
		op_j    = 6'b100100,
		op_beq  = 6'b100110,
		op_bne  = 6'b100111,
		op_addi = 6'b101000
	} opcode_e;

	// also the sub-op encoding of register ALU instructions
	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_xor = 3'd4,
		alu_slt = 3'd5
	} alu_op_e;

	typedef struct packed {
		alu_op_e   alu_op;
		logic      use_imm;
		logic      reg_write;
		logic      mem_read;
		logic      mem_write;
		reg_addr_t rd;
	} ctrl_t;

	typedef struct packed {
		word_t inst;
		word_t pc;
	} if_id_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t a;
		word_t b;
		word_t store_data;
		word_t imm;
	} id_ex_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t result;
		word_t store_data;
	} ex_mem_t;

	typedef struct packed {
		logic      reg_write;
		reg_addr_t rd;
		word_t     data;
	} mem_wb_t;

endpackage

// File: source/alu.sv
`timescale 1ns/1ps

module alu (
	input  cpu_pkg::word_t   a,
	input  cpu_pkg::word_t   b,
	input  cpu_pkg::alu_op_e op,
	output cpu_pkg::word_t   result,
	output logic             overflow
);
	import cpu_pkg::*;

	word_t sum;
	word_t diff;

	assign sum = a + b;
	assign diff = a - b;

	always_comb begin
		result = '0;
		overflow = 1'b0;
		case (op)
			alu_add: begin
				result = sum;
				// same-sign operands, sign flipped
				overflow = (a[31] == b[31]) && (sum[31] != a[31]);
			end
			alu_sub: begin
				result = diff;
				overflow = (a[31] != b[31]) && (diff[31] != a[31]);
			end
			alu_and: result = a & b;
			alu_or:  result = a | b;
			alu_xor: result = a ^ b;
			alu_slt: result = word_t'($signed(a) < $signed(b));
			default: result = '0;
		endcase
	end

endmodule

// File: source/regfile.sv
`timescale 1ns/1ps

module regfile (
	input  logic               clk,
	input  logic               rst,
	input  cpu_pkg::reg_addr_t ra_addr,
	input  cpu_pkg::reg_addr_t rb_addr,
	input  cpu_pkg::reg_addr_t rt_addr,
	input  logic               wr_en,
	input  cpu_pkg::reg_addr_t wr_addr,
	input  cpu_pkg::word_t     wr_data,
	output cpu_pkg::word_t     ra_data,
	output cpu_pkg::word_t     rb_data,
	output cpu_pkg::word_t     rt_data
);
	import cpu_pkg::*;

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_addr != '0) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// write-through so WB lands in the same cycle as decode
	function automatic word_t read_port(input reg_addr_t addr);
		if (wr_en && addr != '0 && addr == wr_addr)
			return wr_data;
		return regs[addr];
	endfunction

	always_comb begin
		ra_data = read_port(ra_addr);
		rb_data = read_port(rb_addr);
		rt_data = read_port(rt_addr);
	end

endmodule

// File: source/controller.sv
`timescale 1ns/1ps

module controller (
	input  cpu_pkg::word_t inst,
	output cpu_pkg::ctrl_t ctrl,
	output cpu_pkg::word_t imm,
	output logic           is_branch,
	output logic           is_bne,
	output logic           is_jump
);
	import cpu_pkg::*;

	opcode_e    opcode;
	logic [4:0] sub_op;
	word_t      imm14;

	assign opcode = opcode_e'(inst[30:25]);
	assign sub_op = inst[4:0];
	assign imm14 = {{18{inst[13]}}, inst[13:0]};

	always_comb begin
		ctrl = '0;
		imm = '0;
		is_branch = 1'b0;
		is_bne = 1'b0;
		is_jump = 1'b0;
		case (opcode)
			op_alu: begin
				// unused sub-ops fall through as a no-op
				if (sub_op[4:3] == 2'b00 && sub_op[2:0] <= 3'(alu_slt)) begin
					ctrl.alu_op = alu_op_e'(sub_op[2:0]);
					ctrl.reg_write = 1'b1;
					ctrl.rd = inst[24:20];
				end
			end
			op_addi: begin
				imm = {{17{inst[14]}}, inst[14:0]};
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.rd = inst[24:20];
			end
			op_lw: begin
				imm = imm14;
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.mem_read = 1'b1;
				ctrl.rd = inst[24:20];
			end
			op_sw: begin
				imm = imm14;
				ctrl.use_imm = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			op_beq: begin
				imm = imm14;
				is_branch = 1'b1;
			end
			op_bne: begin
				imm = imm14;
				is_branch = 1'b1;
				is_bne = 1'b1;
			end
			op_j: begin
				imm = {{8{inst[23]}}, inst[23:0]};
				is_jump = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

// File: source/pc.sv
`timescale 1ns/1ps

module pc #(
	parameter int PC_WIDTH = 10
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                stall,
	input  logic [PC_WIDTH-1:0] id_pc,
	input  logic                is_branch,
	input  logic                is_bne,
	input  logic                is_jump,
	input  cpu_pkg::word_t      offset,
	input  cpu_pkg::word_t      ra_val,
	input  cpu_pkg::word_t      rt_val,
	output logic [PC_WIDTH-1:0] pc,
	output logic                flush
);

	logic                taken;
	logic [PC_WIDTH-1:0] target;

	assign taken = is_jump || (is_branch && ((ra_val == rt_val) != is_bne));
	assign target = id_pc + offset[PC_WIDTH-1:0];

	// operands are stale while stalled, so no redirect then
	assign flush = taken && !stall;

	always_ff @(posedge clk) begin
		if (rst)
			pc <= '0;
		else if (flush)
			pc <= target;
		else if (!stall)
			pc <= pc + 1'b1;
	end

endmodule

// File: source/forward.sv
`timescale 1ns/1ps

module forward (
	input  cpu_pkg::reg_addr_t id_ra,
	input  cpu_pkg::reg_addr_t id_rb,
	input  cpu_pkg::reg_addr_t id_rt,
	input  cpu_pkg::word_t     ra_reg,
	input  cpu_pkg::word_t     rb_reg,
	input  cpu_pkg::word_t     rt_reg,
	input  cpu_pkg::id_ex_t    ex,
	input  cpu_pkg::word_t     ex_result,
	input  cpu_pkg::mem_wb_t   mem_wb_next,
	input  cpu_pkg::mem_wb_t   wb,
	output cpu_pkg::word_t     ra_val,
	output cpu_pkg::word_t     rb_val,
	output cpu_pkg::word_t     rt_val,
	output logic               hazard
);
	import cpu_pkg::*;

	// youngest producer wins
	function automatic word_t pick(input reg_addr_t r, input word_t rf_val);
		if (r == '0)
			return rf_val;
		if (ex.ctrl.reg_write && ex.ctrl.rd == r)
			return ex_result;
		if (mem_wb_next.reg_write && mem_wb_next.rd == r)
			return mem_wb_next.data;
		if (wb.reg_write && wb.rd == r)
			return wb.data;
		return rf_val;
	endfunction

	always_comb begin
		ra_val = pick(id_ra, ra_reg);
		rb_val = pick(id_rb, rb_reg);
		rt_val = pick(id_rt, rt_reg);
	end

	// load data only exists after MEM
	always_comb begin
		hazard = 1'b0;
		if (ex.ctrl.mem_read && ex.ctrl.rd != '0)
			hazard = (ex.ctrl.rd == id_ra) || (ex.ctrl.rd == id_rb) || (ex.ctrl.rd == id_rt);
	end

endmodule

// File: source/regwalls.sv
`timescale 1ns/1ps

module regwalls #(
	parameter int PC_WIDTH = 10
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              stall,
	input  logic              flush,
	input  cpu_pkg::if_id_t   if_in,
	input  cpu_pkg::id_ex_t   id_in,
	input  cpu_pkg::ex_mem_t  ex_in,
	input  cpu_pkg::mem_wb_t  mem_in,
	output cpu_pkg::if_id_t   if_out,
	output cpu_pkg::id_ex_t   id_out,
	output cpu_pkg::ex_mem_t  ex_out,
	output cpu_pkg::mem_wb_t  wb_out
);
	import cpu_pkg::*;

	if_id_t if_next;

	// only the implemented pc bits are kept
	always_comb begin
		if_next = if_in;
		if_next.pc = word_t'(if_in.pc[PC_WIDTH-1:0]);
	end

	// fetch to decode
	always_ff @(posedge clk) begin
		if (rst)
			if_out <= '0;
		else if (flush)
			if_out <= '0;
		else if (!stall)
			if_out <= if_next;
	end

	// decode to execute, bubble on load-use
	always_ff @(posedge clk) begin
		if (rst || stall)
			id_out <= '0;
		else
			id_out <= id_in;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_out <= '0;
			wb_out <= '0;
		end else begin
			ex_out <= ex_in;
			wb_out <= mem_in;
		end
	end

endmodule

// File: source/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
	parameter int PC_WIDTH      = 10,
	parameter int DM_ADDR_WIDTH = 12
) (
	input  logic                     clk,
	input  logic                     rst,
	input  cpu_pkg::word_t           instruction,
	output logic [PC_WIDTH-1:0]      im_address,
	output logic                     dm_read,
	output logic                     dm_write,
	output logic [DM_ADDR_WIDTH-1:0] dm_address,
	output cpu_pkg::word_t           dm_in,
	input  cpu_pkg::word_t           dm_out,
	output logic                     overflow
);
	import cpu_pkg::*;

	logic [PC_WIDTH-1:0] pc_q;
	logic      stall, flush, is_branch, is_bne, is_jump, alu_ovf;
	if_id_t    if_in, if_id;
	id_ex_t    id_in, id_ex;
	ex_mem_t   ex_in, ex_mem;
	mem_wb_t   mem_in, mem_wb;
	ctrl_t     id_ctrl;
	reg_addr_t id_ra, id_rb, id_rt;
	word_t     imm, ra_reg, rb_reg, rt_reg, ra_val, rb_val, rt_val;
	word_t     alu_b, alu_result;

	assign im_address = pc_q;
	assign if_in = '{inst: instruction, pc: word_t'(pc_q)};

	assign id_ra = if_id.inst[19:15];
	assign id_rb = if_id.inst[14:10];
	assign id_rt = if_id.inst[24:20];
	assign id_in = '{ctrl: id_ctrl, a: ra_val, b: rb_val, store_data: rt_val, imm: imm};

	// operand b mux in EX
	assign alu_b = id_ex.ctrl.use_imm ? id_ex.imm : id_ex.b;
	assign ex_in = '{ctrl: id_ex.ctrl, result: alu_result, store_data: id_ex.store_data};

	assign dm_read = ex_mem.ctrl.mem_read;
	assign dm_write = ex_mem.ctrl.mem_write;
	assign dm_address = ex_mem.result[DM_ADDR_WIDTH-1:0];
	assign dm_in = ex_mem.store_data;

	// load result mux
	assign mem_in.reg_write = ex_mem.ctrl.reg_write;
	assign mem_in.rd = ex_mem.ctrl.rd;
	assign mem_in.data = ex_mem.ctrl.mem_read ? dm_out : ex_mem.result;

	// sticky, only arithmetic writers count
	always_ff @(posedge clk) begin
		if (rst)
			overflow <= 1'b0;
		else if (alu_ovf && id_ex.ctrl.reg_write && !id_ex.ctrl.mem_read)
			overflow <= 1'b1;
	end

	controller u_controller (.inst(if_id.inst), .ctrl(id_ctrl), .imm(imm),
		.is_branch(is_branch), .is_bne(is_bne), .is_jump(is_jump));

	regfile u_regfile (.clk(clk), .rst(rst), .ra_addr(id_ra), .rb_addr(id_rb), .rt_addr(id_rt),
		.wr_en(mem_wb.reg_write), .wr_addr(mem_wb.rd), .wr_data(mem_wb.data),
		.ra_data(ra_reg), .rb_data(rb_reg), .rt_data(rt_reg));

	forward u_forward (.id_ra(id_ra), .id_rb(id_rb), .id_rt(id_rt),
		.ra_reg(ra_reg), .rb_reg(rb_reg), .rt_reg(rt_reg),
		.ex(id_ex), .ex_result(alu_result), .mem_wb_next(mem_in), .wb(mem_wb),
		.ra_val(ra_val), .rb_val(rb_val), .rt_val(rt_val), .hazard(stall));

	pc #(.PC_WIDTH(PC_WIDTH)) u_pc (.clk(clk), .rst(rst), .stall(stall),
		.id_pc(if_id.pc[PC_WIDTH-1:0]), .is_branch(is_branch), .is_bne(is_bne),
		.is_jump(is_jump), .offset(imm), .ra_val(ra_val), .rt_val(rt_val),
		.pc(pc_q), .flush(flush));

	alu u_alu (.a(id_ex.a), .b(alu_b), .op(id_ex.ctrl.alu_op),
		.result(alu_result), .overflow(alu_ovf));

	regwalls #(.PC_WIDTH(PC_WIDTH)) u_regwalls (.clk(clk), .rst(rst), .stall(stall),
		.flush(flush), .if_in(if_in), .id_in(id_in), .ex_in(ex_in), .mem_in(mem_in),
		.if_out(if_id), .id_out(id_ex), .ex_out(ex_mem), .wb_out(mem_wb));

endmodule

// File: tb/cpu_asserts.sv
`timescale 1ns/1ps

module cpu_asserts (
	input logic clk,
	input logic rst,
	input logic dm_read,
	input logic dm_write,
	input logic overflow
);

	// one access per cycle
	a_dm_exclusive: assert property (@(posedge clk) !(dm_read && dm_write))
		else $error("dm_read and dm_write high in the same cycle");

	// walls are cleared one edge into reset
	a_no_access_in_reset: assert property (@(posedge clk) rst |=> !(dm_read || dm_write))
		else $error("memory access while in reset");

	a_overflow_sticky: assert property (@(posedge clk) $fell(overflow) |-> $past(rst))
		else $error("overflow cleared without reset");

endmodule

bind cpu_top cpu_asserts u_cpu_asserts (
	.clk(clk),
	.rst(rst),
	.dm_read(dm_read),
	.dm_write(dm_write),
	.overflow(overflow)
);

// File: tb/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;
	import cpu_pkg::*;

	localparam int PC_WIDTH = 10;
	localparam int DM_ADDR_WIDTH = 12;
	localparam int BODY_MAX = 40;
	localparam int PROG_MAX = BODY_MAX + 32;
	localparam int NUM_RUNS = 10;
	localparam int WATCHDOG_NS = NUM_RUNS * (PROG_MAX * 2 + 40) * 4;
	localparam int STORE_BASE = 3000;
	localparam int K_ALU = 0;
	localparam int K_MEM = 1;
	localparam int K_BRANCH = 2;
	localparam int K_OVF = 3;

	typedef logic [DM_ADDR_WIDTH-1:0] dm_addr_t;

	logic                clk;
	logic                rst;
	word_t               instruction;
	logic [PC_WIDTH-1:0] im_address;
	logic                dm_read;
	logic                dm_write;
	dm_addr_t            dm_address;
	word_t               dm_in;
	word_t               dm_out;
	logic                overflow;

	word_t    imem [2**PC_WIDTH];
	word_t    dmem [2**DM_ADDR_WIDTH];
	word_t    model_mem [2**DM_ADDR_WIDTH];
	dm_addr_t cap_addr [$];
	word_t    cap_data [$];
	dm_addr_t exp_addr [$];
	word_t    exp_data [$];
	logic     exp_ovf;
	string    test_name;
	int       errors;
	int       passed;
	int       failed;

	cpu_top #(.PC_WIDTH(PC_WIDTH), .DM_ADDR_WIDTH(DM_ADDR_WIDTH)) u_cpu_top (.*);

	always #2 clk = ~clk;

	assign instruction = imem[im_address];
	// read data only while the DUT asks for it
	assign dm_out = dm_read ? dmem[dm_address] : '0;

	// store lands mid-cycle, visible to the next load
	always @(negedge clk) begin
		if (dm_write)
			dmem[dm_address] = dm_in;
		if (!rst && dm_write) begin
			cap_addr.push_back(dm_address);
			cap_data.push_back(dm_in);
		end
	end

	function automatic word_t fill_word(input dm_addr_t a);
		return {a, 4'ha, ~a, 4'h5};
	endfunction

	function automatic word_t enc_alu(input alu_op_e op, input reg_addr_t rt, ra, rb);
		return {1'b0, op_alu, rt, ra, rb, 5'd0, 2'b00, op};
	endfunction

	function automatic word_t enc_imm(input opcode_e op, input reg_addr_t rt, ra,
			input logic [14:0] imm);
		return {1'b0, op, rt, ra, imm};
	endfunction

	function automatic word_t enc_jump(input logic [23:0] off);
		return {1'b0, op_j, 1'b0, off};
	endfunction

	function automatic reg_addr_t rand_reg(input int span);
		return reg_addr_t'($urandom % span);
	endfunction

	function automatic word_t model_alu(input alu_op_e op, input word_t a, input word_t b,
			output logic ovf);
		longint sa;
		longint sb;
		longint wide;
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		ovf = 1'b0;
		case (op)
			alu_add: wide = sa + sb;
			alu_sub: wide = sa - sb;
			alu_and: return a & b;
			alu_or:  return a | b;
			alu_xor: return a ^ b;
			default: return (sa < sb) ? 32'd1 : 32'd0;
		endcase
		// outside the signed 32-bit range
		ovf = (wide > 64'sd2147483647) || (wide < -64'sd2147483648);
		return word_t'(wide);
	endfunction

	task automatic gen_program(input int kind, input int n);
		reg_addr_t prev;
		reg_addr_t rt;
		reg_addr_t ra;
		logic      prev_load;
		int        pick;
		int        off;
		int        v;
		prev = '0;
		prev_load = 1'b0;
		foreach (imem[i])
			imem[i] = '0;
		for (int i = 0; i < n; i++) begin
			pick = int'($urandom % 100);
			rt = rand_reg(kind == K_BRANCH ? 4 : 8);
			// lean on the last destination for dense dependences
			ra = (prev_load || $urandom % 2 == 1) ? prev : rand_reg(kind == K_BRANCH ? 4 : 8);
			prev_load = 1'b0;
			off = 1 + int'($urandom % 4);
			if (i + off > n)
				off = n - i;
			case (kind)
				K_ALU: begin
					if (pick < 40)
						imem[i] = enc_imm(op_addi, rt, ra, 15'($urandom));
					else
						imem[i] = enc_alu(alu_op_e'(3'($urandom % 6)), rt, ra, rand_reg(8));
				end
				K_MEM: begin
					if (pick < 30) begin
						imem[i] = enc_imm(op_lw, rt, ra, {1'b0, 14'($urandom % 64)});
						prev_load = 1'b1;
					end else if (pick < 55)
						imem[i] = enc_imm(op_sw, rt, ra, {1'b0, 14'($urandom % 64)});
					else if (pick < 75)
						imem[i] = enc_imm(op_addi, rt, ra, 15'($urandom));
					else
						imem[i] = enc_alu(alu_op_e'(3'($urandom % 6)), rt, ra, rand_reg(8));
				end
				K_BRANCH: begin
					if (pick < 25)
						imem[i] = enc_imm(pick < 13 ? op_beq : op_bne, rt, ra, 15'(off));
					else if (pick < 35)
						imem[i] = enc_jump(24'(off));
					else if (pick < 70)
						imem[i] = enc_imm(op_addi, rt, ra, 15'($urandom % 4));
					else
						imem[i] = enc_alu(alu_op_e'(3'($urandom % 6)), rt, ra, rand_reg(4));
				end
				default: begin
					// doubling chain from a large seed, overflows only if long enough
					v = 8192 + int'($urandom % 8192);
					if ($urandom % 2 == 1)
						v = -v;
					if (i == 0)
						imem[i] = enc_imm(op_addi, 5'd1, 5'd0, 15'(v));
					else if (pick < 80)
						imem[i] = enc_alu(alu_add, 5'd1, 5'd1, 5'd1);
					else if (pick < 92)
						imem[i] = enc_alu(alu_sub, 5'd2, 5'd2, 5'd1);
					else
						imem[i] = enc_imm(op_addi, 5'd1, 5'd1, 15'(v));
				end
			endcase
			prev = rt;
		end
		for (int r = 1; r < 32; r++)
			imem[n + r - 1] = enc_imm(op_sw, reg_addr_t'(r), '0, 15'(STORE_BASE + r));
		imem[n + 31] = enc_jump('0);
	endtask

	// sequential ISA model over imem and model_mem
	task automatic run_model();
		word_t               regs [32];
		logic [PC_WIDTH-1:0] pc;
		word_t               inst;
		word_t               a;
		word_t               t;
		word_t               res;
		dm_addr_t            addr;
		logic                ovf;
		logic                taken;
		foreach (regs[i])
			regs[i] = '0;
		pc = '0;
		exp_ovf = 1'b0;
		exp_addr.delete();
		exp_data.delete();
		for (int step = 0; step < 4 * PROG_MAX; step++) begin
			inst = imem[pc];
			if (inst[30:25] == op_j && inst[23:0] == '0)
				break;
			a = regs[inst[19:15]];
			t = regs[inst[24:20]];
			addr = dm_addr_t'(a + {{18{inst[13]}}, inst[13:0]});
			ovf = 1'b0;
			taken = 1'b0;
			case (opcode_e'(inst[30:25]))
				op_alu: begin
					res = model_alu(alu_op_e'(inst[2:0]), a, regs[inst[14:10]], ovf);
					regs[inst[24:20]] = res;
				end
				op_addi: begin
					res = model_alu(alu_add, a, {{17{inst[14]}}, inst[14:0]}, ovf);
					regs[inst[24:20]] = res;
				end
				op_lw: regs[inst[24:20]] = model_mem[addr];
				op_sw: begin
					model_mem[addr] = t;
					exp_addr.push_back(addr);
					exp_data.push_back(t);
				end
				op_beq: taken = (a == t);
				op_bne: taken = (a != t);
				op_j:   taken = 1'b1;
				default: ;
			endcase
			regs[0] = '0;
			exp_ovf = exp_ovf | ovf;
			if (taken)
				pc = pc + inst[PC_WIDTH-1:0];
			else
				pc = pc + PC_WIDTH'(1);
		end
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_addr(input string name, input dm_addr_t exp, input dm_addr_t act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %b, actual %b", name, exp, act);
			errors++;
		end
	endtask

	// entered 1 ns after a rising edge
	task automatic start_program(input int kind, input int n);
		rst = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		gen_program(kind, n);
		foreach (dmem[i]) begin
			dmem[i] = fill_word(dm_addr_t'(i));
			model_mem[i] = dmem[i];
		end
		run_model();
		cap_addr.delete();
		cap_data.delete();
		check_word({test_name, " pc in reset"}, '0, word_t'(im_address));
		rst = 1'b0;
		// nothing reaches MEM yet
		for (int c = 0; c < 2; c++) begin
			@(negedge clk);
			if (c == 0)
				check_word({test_name, " first pc"}, '0, word_t'(im_address));
			check_flag({test_name, " idle dm_read"}, 1'b0, dm_read);
			check_flag({test_name, " idle dm_write"}, 1'b0, dm_write);
			check_flag({test_name, " idle overflow"}, 1'b0, overflow);
		end
	endtask

	task automatic finish_program();
		int cycles;
		int n;
		cycles = 0;
		while (cap_addr.size() < exp_addr.size() && cycles < PROG_MAX * 2 + 20) begin
			@(negedge clk);
			cycles++;
		end
		// stray stores would show up here
		repeat (8) @(posedge clk);
		#1;
		if (cap_addr.size() != exp_addr.size()) begin
			$display("%s: the DUT made %0d stores where the model made %0d", test_name,
				cap_addr.size(), exp_addr.size());
			errors++;
		end
		n = (cap_addr.size() < exp_addr.size()) ? cap_addr.size() : exp_addr.size();
		for (int i = 0; i < n; i++) begin
			check_addr($sformatf("%s store %0d address", test_name, i), exp_addr[i], cap_addr[i]);
			check_word($sformatf("%s store %0d data", test_name, i), exp_data[i], cap_data[i]);
		end
		check_flag({test_name, " overflow"}, exp_ovf, overflow);
	endtask

	task automatic report_test(input int base);
		if (errors == base) begin
			passed++;
			$display("test %s: pass", test_name);
		end else begin
			failed++;
			$display("test %s: fail with %0d errors", test_name, errors - base);
		end
	endtask

	task automatic run_test(input string name, input int kind, input int n);
		int base;
		base = errors;
		test_name = name;
		start_program(kind, n);
		finish_program();
		report_test(base);
	endtask

	initial begin
		int base;
		clk = 1'b0;
		rst = 1'b1;
		errors = 0;
		passed = 0;
		failed = 0;
		foreach (imem[i])
			imem[i] = '0;
		foreach (dmem[i])
			dmem[i] = '0;
		void'($urandom(78708));
		run_test("alu_dense_a", K_ALU, BODY_MAX);
		run_test("alu_dense_b", K_ALU, BODY_MAX);
		run_test("load_store_a", K_MEM, BODY_MAX);
		run_test("load_store_b", K_MEM, BODY_MAX);
		run_test("branch_a", K_BRANCH, BODY_MAX);
		run_test("branch_b", K_BRANCH, BODY_MAX);
		run_test("overflow_a", K_OVF, 12 + int'($urandom % 15));
		run_test("overflow_b", K_OVF, 12 + int'($urandom % 15));
		// reset hits while the first program is still running
		base = errors;
		test_name = "mid_reset";
		start_program(K_OVF, 26);
		repeat (20 + $urandom % 10) @(posedge clk);
		#1;
		start_program(K_ALU, BODY_MAX);
		finish_program();
		report_test(base);
		$display("tests passed: %0d, tests failed: %0d", passed, failed);
		if (failed == 0 && errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the DUT stopped making progress", WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: tb.f
source/cpu_pkg.sv
source/alu.sv
source/regfile.sv
source/controller.sv
source/pc.sv
source/forward.sv
source/regwalls.sv
source/cpu_top.sv
tb/cpu_asserts.sv
tb/tb_cpu.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_cpu
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Simulation passed$$" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
